// ==== verilog/lc3b_alu_pkg.sv ====
package lc3b_alu_pkg;

	// datapath widths
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [3:0] lc3b_opcode;

	// n, z, p from high bit to low
	typedef logic [2:0] lc3b_nzp;

	typedef logic [2:0] lc3b_aluop;

	// operate instructions handled by the core
	localparam lc3b_opcode OP_ADD = 4'b0001;
	localparam lc3b_opcode OP_AND = 4'b0101;
	localparam lc3b_opcode OP_NOT = 4'b1001;
	localparam lc3b_opcode OP_SHF = 4'b1101;

	// alu operation select
	localparam lc3b_aluop ALU_ADD = 3'd0;
	localparam lc3b_aluop ALU_AND = 3'd1;
	localparam lc3b_aluop ALU_NOT = 3'd2;
	localparam lc3b_aluop ALU_SLL = 3'd3;
	localparam lc3b_aluop ALU_SRL = 3'd4;
	localparam lc3b_aluop ALU_SRA = 3'd5;

	// register file depth
	localparam int NUM_REGS = 8;

	// cc after reset is Z
	localparam lc3b_nzp CC_RESET = 3'b010;

endpackage : lc3b_alu_pkg

// ==== verilog/lc3b_decode.sv ====
`timescale 1ns/1ps

module lc3b_decode import lc3b_alu_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic instr_valid,
	input lc3b_word instr,

	output lc3b_reg src_a,
	output lc3b_reg src_b,

	output logic d_valid,
	output lc3b_aluop d_aluop,
	output lc3b_reg d_dest,
	output logic d_use_imm,
	output lc3b_word d_imm
);

	lc3b_word ir;
	logic ir_valid;

	lc3b_opcode opcode;
	lc3b_word imm5_sext;
	lc3b_word shamt_zext;
	logic supported;

	// instruction register
	always_ff @(posedge clk) begin
		if (rst) begin
			ir_valid <= 1'b0;
		end else begin
			ir_valid <= instr_valid;
		end
	end

	// word itself is payload only
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ir <= instr;
		end
	end

	// fixed fields
	assign opcode = lc3b_opcode'(ir[15:12]);
	assign d_dest = ir[11:9];
	assign src_a = ir[8:6];
	assign src_b = ir[2:0];

	// immediates
	assign imm5_sext = {{11{ir[4]}}, ir[4:0]};
	assign shamt_zext = {12'h000, ir[3:0]};

	always_comb begin
		supported = 1'b1;
		d_aluop = ALU_ADD;
		d_use_imm = 1'b0;
		d_imm = imm5_sext;
		case (opcode)
			OP_ADD: begin
				d_aluop = ALU_ADD;
				d_use_imm = ir[5];
			end
			OP_AND: begin
				d_aluop = ALU_AND;
				d_use_imm = ir[5];
			end
			OP_NOT: begin
				// xor with all ones in the alu
				d_aluop = ALU_NOT;
				d_use_imm = 1'b1;
				d_imm = 16'hffff;
			end
			OP_SHF: begin
				d_use_imm = 1'b1;
				d_imm = shamt_zext;
				// bit 4 picks direction, bit 5 arithmetic
				if (!ir[4]) begin
					d_aluop = ALU_SLL;
				end else if (ir[5]) begin
					d_aluop = ALU_SRA;
				end else begin
					d_aluop = ALU_SRL;
				end
			end
			default: begin
				supported = 1'b0;
			end
		endcase
	end

	// anything else becomes a bubble
	assign d_valid = ir_valid & supported;

endmodule : lc3b_decode

// ==== verilog/lc3b_regfile.sv ====
`timescale 1ns/1ps

module lc3b_regfile import lc3b_alu_pkg::*;
(
	input logic clk,
	input logic rst,

	input lc3b_reg src_a,
	input lc3b_reg src_b,
	output lc3b_word rd_a,
	output lc3b_word rd_b,

	input logic w_valid,
	input lc3b_reg w_dest,
	input lc3b_word w_data
);

	lc3b_word regs [NUM_REGS];

	logic hit_a;
	logic hit_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= 16'h0000;
			end
		end else if (w_valid) begin
			regs[w_dest] <= w_data;
		end
	end

	// write-through on a same-cycle write
	assign hit_a = w_valid && (w_dest == src_a);
	assign hit_b = w_valid && (w_dest == src_b);

	assign rd_a = hit_a ? w_data : regs[src_a];
	assign rd_b = hit_b ? w_data : regs[src_b];

endmodule : lc3b_regfile

// ==== verilog/lc3b_execute.sv ====
`timescale 1ns/1ps

module lc3b_execute import lc3b_alu_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic d_valid,
	input lc3b_aluop d_aluop,
	input lc3b_reg d_dest,
	input logic d_use_imm,
	input lc3b_word d_imm,
	input lc3b_reg d_src_a,
	input lc3b_reg d_src_b,
	input lc3b_word rd_a,
	input lc3b_word rd_b,

	input logic w_valid,
	input lc3b_reg w_dest,
	input lc3b_word w_data,

	output logic e_valid,
	output lc3b_reg e_dest,
	output lc3b_word e_result
);

	// id/ex register
	logic valid_q;
	lc3b_aluop aluop_q;
	lc3b_reg dest_q;
	logic use_imm_q;
	lc3b_word imm_q;
	lc3b_reg src_a_q;
	lc3b_reg src_b_q;
	lc3b_word op_a_q;
	lc3b_word op_b_q;

	logic fwd_a;
	logic fwd_b;
	lc3b_word alu_a;
	lc3b_word alu_b;
	lc3b_word alu_f;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= d_valid;
		end
	end

	always_ff @(posedge clk) begin
		aluop_q <= d_aluop;
		dest_q <= d_dest;
		use_imm_q <= d_use_imm;
		imm_q <= d_imm;
		src_a_q <= d_src_a;
		src_b_q <= d_src_b;
		op_a_q <= rd_a;
		op_b_q <= rd_b;
	end

	// result sitting in writeback is newer than what was read
	assign fwd_a = w_valid && (w_dest == src_a_q);
	assign fwd_b = w_valid && (w_dest == src_b_q);

	assign alu_a = fwd_a ? w_data : op_a_q;

	always_comb begin
		if (use_imm_q) begin
			alu_b = imm_q;
		end else if (fwd_b) begin
			alu_b = w_data;
		end else begin
			alu_b = op_b_q;
		end
	end

	// alu
	always_comb begin
		case (aluop_q)
			ALU_ADD: alu_f = alu_a + alu_b;
			ALU_AND: alu_f = alu_a & alu_b;
			// b is all ones here
			ALU_NOT: alu_f = alu_a ^ alu_b;
			ALU_SLL: alu_f = alu_a << alu_b[3:0];
			ALU_SRL: alu_f = alu_a >> alu_b[3:0];
			ALU_SRA: alu_f = lc3b_word'($signed(alu_a) >>> alu_b[3:0]);
			default: alu_f = alu_a;
		endcase
	end

	assign e_valid = valid_q;
	assign e_dest = dest_q;
	assign e_result = alu_f;

endmodule : lc3b_execute

// ==== verilog/lc3b_writeback.sv ====
`timescale 1ns/1ps

module lc3b_writeback import lc3b_alu_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic e_valid,
	input lc3b_reg e_dest,
	input lc3b_word e_result,

	output logic w_valid,
	output lc3b_reg w_dest,
	output lc3b_word w_data,
	output lc3b_nzp cc
);

	lc3b_nzp gencc;

	// ex/wb register
	always_ff @(posedge clk) begin
		if (rst) begin
			w_valid <= 1'b0;
		end else begin
			w_valid <= e_valid;
		end
	end

	always_ff @(posedge clk) begin
		w_dest <= e_dest;
		w_data <= e_result;
	end

	// sign and zero test
	always_comb begin
		if (w_data[15]) begin
			gencc = 3'b100;
		end else if (w_data == 16'h0000) begin
			gencc = 3'b010;
		end else begin
			gencc = 3'b001;
		end
	end

	// cc follows the regfile write
	always_ff @(posedge clk) begin
		if (rst) begin
			cc <= CC_RESET;
		end else if (w_valid) begin
			cc <= gencc;
		end
	end

endmodule : lc3b_writeback

// ==== verilog/lc3b_alu_core.sv ====
`timescale 1ns/1ps

module lc3b_alu_core import lc3b_alu_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic instr_valid,
	input lc3b_word instr,

	output logic wb_valid,
	output lc3b_reg wb_dest,
	output lc3b_word wb_data,
	output lc3b_nzp cc
);

	// decode side
	lc3b_reg src_a;
	lc3b_reg src_b;
	lc3b_word rd_a;
	lc3b_word rd_b;
	logic d_valid;
	lc3b_aluop d_aluop;
	lc3b_reg d_dest;
	logic d_use_imm;
	lc3b_word d_imm;

	// execute side
	logic e_valid;
	lc3b_reg e_dest;
	lc3b_word e_result;

	lc3b_decode decode
	(
		.clk,
		.rst,
		.instr_valid(instr_valid),
		.instr(instr),
		.src_a(src_a),
		.src_b(src_b),
		.d_valid(d_valid),
		.d_aluop(d_aluop),
		.d_dest(d_dest),
		.d_use_imm(d_use_imm),
		.d_imm(d_imm)
	);

	// writeback port doubles as the top outputs
	lc3b_regfile regfile
	(
		.clk,
		.rst,
		.src_a(src_a),
		.src_b(src_b),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.w_valid(wb_valid),
		.w_dest(wb_dest),
		.w_data(wb_data)
	);

	lc3b_execute execute
	(
		.clk,
		.rst,
		.d_valid(d_valid),
		.d_aluop(d_aluop),
		.d_dest(d_dest),
		.d_use_imm(d_use_imm),
		.d_imm(d_imm),
		.d_src_a(src_a),
		.d_src_b(src_b),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.w_valid(wb_valid),
		.w_dest(wb_dest),
		.w_data(wb_data),
		.e_valid(e_valid),
		.e_dest(e_dest),
		.e_result(e_result)
	);

	lc3b_writeback writeback
	(
		.clk,
		.rst,
		.e_valid(e_valid),
		.e_dest(e_dest),
		.e_result(e_result),
		.w_valid(wb_valid),
		.w_dest(wb_dest),
		.w_data(wb_data),
		.cc(cc)
	);

endmodule : lc3b_alu_core

// ==== testbench/lc3b_alu_core_chk.sv ====
`timescale 1ns/1ps

module lc3b_alu_core_chk import lc3b_alu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic wb_valid,
	input lc3b_word wb_data,
	input lc3b_nzp cc
);

	// no writeback straight out of reset
	a_quiet_after_rst: assert property (@(posedge clk) rst |=> !wb_valid)
		else $error("wb_valid high in the cycle after reset");

	a_cc_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(cc))
		else $error("cc is not one-hot");

	// cc is loaded one edge after the result shows
	a_cc_follows: assert property (@(posedge clk) disable iff (rst)
		wb_valid |=> cc == {$past(wb_data[15]), $past(wb_data) == 16'h0000,
			!$past(wb_data[15]) && $past(wb_data) != 16'h0000})
		else $error("cc does not match the sign of the previous wb_data");

endmodule : lc3b_alu_core_chk

bind lc3b_alu_core lc3b_alu_core_chk chk (
	.clk(clk),
	.rst(rst),
	.wb_valid(wb_valid),
	.wb_data(wb_data),
	.cc(cc)
);

// ==== testbench/tb_lc3b_alu_core.sv ====
`timescale 1ns/1ps

module tb_lc3b_alu_core import lc3b_alu_pkg::*; ();

	logic clk;
	logic rst;
	logic instr_valid;
	lc3b_word instr;
	logic wb_valid;
	lc3b_reg wb_dest;
	lc3b_word wb_data;
	lc3b_nzp cc;

	// program rows with the result each one should give
	lc3b_word tbl_instr[$];
	lc3b_word tbl_data[$];
	bit tbl_tight[$];

	lc3b_word model_regs [NUM_REGS];
	lc3b_reg exp_dest[$];
	lc3b_word exp_data[$];
	lc3b_nzp exp_cc[$];
	int exp_edge[$];

	int cycle_count = 0;
	int limit;
	integer seed;
	bit checking;
	bit cc_pending;
	lc3b_nzp cc_due;
	lc3b_nzp cc_now;

	lc3b_alu_core UUT (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.cc(cc)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "run stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= limit) begin
			fail_run($sformatf("timeout: no end of test after %0d cycles", cycle_count));
		end
	end

	task automatic check_reg(input string name, input lc3b_reg got, input lc3b_reg exp);
		if (got !== exp) begin
			fail_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
		if (got !== exp) begin
			fail_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_nzp(input string name, input lc3b_nzp got, input lc3b_nzp exp);
		if (got !== exp) begin
			fail_run($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	function automatic lc3b_word enc_reg(lc3b_opcode opc, int dr, int sr1, int sr2);
		return {opc, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
	endfunction

	function automatic lc3b_word enc_imm(lc3b_opcode opc, int dr, int sr1, int imm);
		return {opc, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
	endfunction

	function automatic lc3b_word enc_not(int dr, int sr);
		return {OP_NOT, dr[2:0], sr[2:0], 6'b111111};
	endfunction

	// kind is {A, D} with 00 lshf, 01 rshfl and 11 rshfa
	function automatic lc3b_word enc_shf(int dr, int sr, logic [1:0] kind, int amt);
		return {OP_SHF, dr[2:0], sr[2:0], kind, amt[3:0]};
	endfunction

	function automatic lc3b_nzp nzp_of(lc3b_word v);
		if (v[15]) begin
			return 3'b100;
		end else if (v == 16'h0000) begin
			return 3'b010;
		end
		return 3'b001;
	endfunction

	task automatic add_row(input lc3b_word ins, input lc3b_word data, input bit tight);
		tbl_instr.push_back(ins);
		tbl_data.push_back(data);
		tbl_tight.push_back(tight);
	endtask

	task automatic build_table();
		// reset value of every register seen through add #0
		for (int r = 0; r < NUM_REGS; r++) begin
			add_row(enc_imm(OP_ADD, r, r, 0), 16'h0000, 1'b0);
		end
		add_row(enc_imm(OP_AND, 1, 1, 0), 16'h0000, 1'b0);
		// back-to-back chain at distances 1 to 3
		add_row(enc_imm(OP_ADD, 1, 1, 5), 16'h0005, 1'b1);
		add_row(enc_imm(OP_ADD, 2, 1, -3), 16'h0002, 1'b1);
		add_row(enc_reg(OP_ADD, 3, 1, 2), 16'h0007, 1'b1);
		add_row(enc_imm(OP_ADD, 4, 3, -8), 16'hffff, 1'b1);
		add_row(enc_not(5, 4), 16'h0000, 1'b1);
		add_row(enc_imm(OP_AND, 6, 4, 15), 16'h000f, 1'b1);
		add_row(enc_reg(OP_ADD, 7, 4, 3), 16'h0006, 1'b1);
		// ldb is not an operate instruction
		add_row(16'h2000, 16'h0000, 1'b0);
		add_row(enc_shf(1, 6, 2'b00, 4), 16'h00f0, 1'b0);
		add_row(enc_shf(2, 4, 2'b01, 15), 16'h0001, 1'b0);
		add_row(enc_shf(3, 4, 2'b11, 7), 16'hffff, 1'b0);
		add_row(enc_shf(5, 7, 2'b00, 15), 16'h0000, 1'b0);
		add_row(enc_shf(5, 7, 2'b00, 0), 16'h0006, 1'b0);
		add_row(enc_imm(OP_ADD, 6, 1, -16), 16'h00e0, 1'b0);
		add_row(enc_not(6, 6), 16'hff1f, 1'b1);
		add_row(enc_shf(7, 6, 2'b11, 4), 16'hfff1, 1'b1);
		add_row(enc_shf(0, 6, 2'b01, 12), 16'h000f, 1'b1);
		// trap slot in the middle of a chain
		add_row(16'hf025, 16'h0000, 1'b1);
		add_row(enc_reg(OP_AND, 1, 7, 6), 16'hff11, 1'b1);
		add_row(enc_reg(OP_AND, 2, 0, 1), 16'h0001, 1'b1);
		add_row(enc_reg(OP_ADD, 3, 2, 2), 16'h0002, 1'b1);
	endtask

	task automatic model_step(input lc3b_word ins, output logic ok, output lc3b_reg dr,
			output lc3b_word res);
		lc3b_word a;
		lc3b_word b;
		int amt;
		ok = 1'b1;
		dr = ins[11:9];
		a = model_regs[ins[8:6]];
		b = ins[5] ? {{11{ins[4]}}, ins[4:0]} : model_regs[ins[2:0]];
		amt = int'(ins[3:0]);
		case (lc3b_opcode'(ins[15:12]))
			OP_ADD: res = a + b;
			OP_AND: res = a & b;
			OP_NOT: res = ~a;
			OP_SHF: begin
				if (!ins[4]) begin
					res = a << amt;
				end else if (ins[5] && a[15]) begin
					res = (a >> amt) | ~(16'hffff >> amt);
				end else begin
					res = a >> amt;
				end
			end
			default: begin
				ok = 1'b0;
				res = 16'h0000;
			end
		endcase
		if (ok) begin
			model_regs[dr] = res;
		end
	endtask

	// outputs are sampled on the falling edge
	always @(negedge clk) begin
		int issued;
		if (checking) begin
			if (cc_pending) begin
				check_nzp("cc", cc, cc_due);
				cc_now = cc_due;
				cc_pending = 1'b0;
			end else begin
				check_nzp("cc", cc, cc_now);
			end
			if (wb_valid) begin
				if (exp_dest.size() == 0) begin
					fail_run($sformatf("writeback at %0t with no instruction outstanding", $time));
				end else begin
					issued = exp_edge.pop_front();
					// driven at edge j and visible after edge j+3
					if (cycle_count != issued + 3) begin
						fail_run($sformatf("result at %0t came %0d edges after issue, not 3",
							$time, cycle_count - issued));
					end
					check_reg("wb_dest", wb_dest, exp_dest.pop_front());
					check_word("wb_data", wb_data, exp_data.pop_front());
					cc_due = exp_cc.pop_front();
					cc_pending = 1'b1;
				end
			end
		end
	end

	initial begin
		int gap;
		logic ok;
		lc3b_reg dr;
		lc3b_word res;
		seed = 32'hbd6d;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = 16'h0000;
		checking = 1'b0;
		cc_pending = 1'b0;
		cc_now = CC_RESET;
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = 16'h0000;
		end
		build_table();
		limit = 4 * tbl_instr.size() + 40;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		checking = 1'b1;
		for (int i = 0; i < tbl_instr.size(); i++) begin
			gap = 0;
			if (!tbl_tight[i]) begin
				gap = $unsigned($random(seed)) % 3;
			end
			repeat (gap) begin
				@(posedge clk);
				instr_valid <= 1'b0;
			end
			@(posedge clk);
			instr_valid <= 1'b1;
			instr <= tbl_instr[i];
			model_step(tbl_instr[i], ok, dr, res);
			if (ok) begin
				if (res !== tbl_data[i]) begin
					fail_run($sformatf("row %0d: table expects %h but the model gives %h",
						i, tbl_data[i], res));
				end
				exp_dest.push_back(dr);
				exp_data.push_back(tbl_data[i]);
				exp_cc.push_back(nzp_of(res));
				exp_edge.push_back(cycle_count + 1);
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		while (exp_dest.size() != 0) begin
			@(posedge clk);
		end
		// last cc lands one edge after its result
		repeat (2) @(posedge clk);
		$display("Testbench passed");
		$finish;
	end

endmodule : tb_lc3b_alu_core

// ==== lc3b_alu_core.f ====
verilog/lc3b_alu_pkg.sv
verilog/lc3b_decode.sv
verilog/lc3b_regfile.sv
verilog/lc3b_execute.sv
verilog/lc3b_writeback.sv
verilog/lc3b_alu_core.sv
testbench/lc3b_alu_core_chk.sv
testbench/tb_lc3b_alu_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert -Wall
TOP = tb_lc3b_alu_core
FILELIST = lc3b_alu_core.f
OBJDIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# pass only when the pass line shows up in the output
run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^Testbench passed$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
